/* verilog.f */
design/exu_pkg.sv
design/exu_issue_stage.sv
design/exu_alu.sv
design/exu_mult_seq.sv
design/exu_branch.sv
design/exu_cdb_arbiter.sv
design/exu_cluster.sv
verif/exu_cluster_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the exu cluster testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert -j 0 --top-module exu_cluster_tb \
	-Mdir "$OBJ_DIR" -f verilog.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$OBJ_DIR/Vexu_cluster_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "FAIL: see errors above" "$LOG"; then
	echo "simulation failed"
	exit 1
fi
if [ $sim_status -ne 0 ] || ! grep -q "PASS: all tests" "$LOG"; then
	echo "simulation did not complete"
	exit 1
fi
echo "simulation passed"
exit 0

/* verif/exu_cluster_tb.sv */
`timescale 1ns/100ps

module exu_cluster_tb import exu_pkg::*; ();

	localparam int WB_CREDITS  = 2;
	localparam int MULT_CYCLES = 4;
	localparam int CLK_PERIOD  = 40;
	localparam int NUM_TESTS   = 5;

	logic       clk;
	logic       rst;
	issue_pkt_t issue_i;
	br_fix_t    fix_i;
	logic       credit_ret_i;
	unit_rdy_t  rdy_o;
	cdb_pkt_t   cdb_o;
	br_res_t    br_res_o;

	integer   seed = 32'h19f2_3dd2;
	int       cyc = 0;
	logic     hold_credits = 1'b0;
	cdb_pkt_t bc_q[$];
	int       bc_edge_q[$];

	exu_cluster #(.WB_CREDITS(WB_CREDITS), .MULT_CYCLES(MULT_CYCLES)) i_exu_cluster (
		.clk          (clk),
		.rst          (rst),
		.issue_i      (issue_i),
		.fix_i        (fix_i),
		.credit_ret_i (credit_ret_i),
		.rdy_o        (rdy_o),
		.cdb_o        (cdb_o),
		.br_res_o     (br_res_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	// every broadcast is logged with the edge that consumes it
	always @(negedge clk) begin
		if (!rst && cdb_o.vld) begin
			bc_q.push_back(cdb_o);
			bc_edge_q.push_back(cyc + 1);
		end
	end

	// downstream consumer, one credit back two cycles after each broadcast
	initial begin : downstream
		logic [1:0] ret_pipe;
		int         owed;
		ret_pipe = '0;
		owed = 0;
		credit_ret_i = 1'b0;
		forever begin
			@(negedge clk);
			ret_pipe = {ret_pipe[0], cdb_o.vld && !rst};
			if (ret_pipe[1])
				owed++;
			@(posedge clk);
			#2;
			if (!hold_credits && owed > 0) begin
				credit_ret_i = 1'b1;
				owed--;
			end else begin
				credit_ret_i = 1'b0;
			end
		end
	end

	initial begin : watchdog
		#(NUM_TESTS * 200 * CLK_PERIOD);
		stop_with_failure("watchdog expired before all tests finished");
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %0t: %s: got 0x%0h, expected 0x%0h",
				$time, what, got, exp));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	function automatic logic [XLEN-1:0] random_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic issue_pkt_t new_packet(fu_sel_e sel, logic [ROB_IDX_W-1:0] rob,
			logic [BR_MASK_W-1:0] mask);
		issue_pkt_t      pkt;
		logic [XLEN-1:0] r;
		r = random_word();
		pkt = '0;
		pkt.vld = 1'b1;
		pkt.sel = sel;
		pkt.rob_idx = rob;
		pkt.br_mask = mask;
		pkt.dest_tag = r[PRF_IDX_W-1:0];
		pkt.npc = {r[XLEN-1:16], 16'h0};
		return pkt;
	endfunction

	function automatic logic unit_ready(fu_sel_e sel);
		case (sel)
			SEL_ALU:    return rdy_o.alu;
			SEL_BRANCH: return rdy_o.br;
			SEL_MULT:   return rdy_o.mult;
			default:    return 1'b1;
		endcase
	endfunction

	function automatic logic [XLEN-1:0] expected_alu(alu_op_e op, logic [XLEN-1:0] a,
			logic [XLEN-1:0] b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << b[5:0];
			ALU_SRL: return a >> b[5:0];
			default: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
		endcase
	endfunction

	function automatic logic expected_taken(br_op_e op, logic [XLEN-1:0] a);
		case (op)
			BR_BEQ:  return a == '0;
			BR_BNE:  return a != '0;
			BR_BLT:  return $signed(a) < 64'sd0;
			default: return 1'b1;
		endcase
	endfunction

	// holds the packet for one edge once its unit is ready
	task automatic issue_op(input issue_pkt_t pkt, output int edge_n);
		int waited;
		waited = 0;
		while (!unit_ready(pkt.sel)) begin
			next_cycle();
			waited++;
			if (waited > 50)
				stop_with_failure("unit never became ready for issue");
		end
		issue_i = pkt;
		edge_n = cyc + 1;
		next_cycle();
		issue_i = '0;
	endtask

	task automatic wait_broadcast(output cdb_pkt_t bc, output int edge_n);
		int waited;
		waited = 0;
		while (bc_q.size() == 0) begin
			next_cycle();
			waited++;
			if (waited > 50)
				stop_with_failure("no CDB broadcast appeared within 50 cycles");
		end
		bc = bc_q.pop_front();
		edge_n = bc_edge_q.pop_front();
	endtask

	task automatic expect_no_broadcast(input int cycles);
		repeat (cycles) next_cycle();
		check_eq(64'(bc_q.size()), 64'd0, "unexpected CDB broadcast");
	endtask

	task automatic alu_op_sweep();
		issue_pkt_t pkt;
		cdb_pkt_t   bc;
		int         issued;
		int         seen;
		int         op;
		for (op = 0; op < 8; op++) begin
			pkt = new_packet(SEL_ALU, 5'(op), '0);
			pkt.alu_op = alu_op_e'(op);
			pkt.opa = random_word();
			pkt.opb = random_word();
			issue_op(pkt, issued);
			wait_broadcast(bc, seen);
			check_eq(bc.value, expected_alu(pkt.alu_op, pkt.opa, pkt.opb),
				$sformatf("alu op %0d value", op));
			check_eq(64'(bc.dest_tag), 64'(pkt.dest_tag), "alu dest_tag");
			check_eq(64'(bc.rob_idx), 64'(pkt.rob_idx), "alu rob_idx");
			check_eq(64'(seen), 64'(issued + 2), "alu broadcast edge");
			expect_no_broadcast(3);
		end
	endtask

	task automatic mult_random_pairs();
		issue_pkt_t pkt;
		cdb_pkt_t   bc;
		int         issued;
		int         seen;
		int         n;
		for (n = 0; n < 3; n++) begin
			pkt = new_packet(SEL_MULT, 5'(8 + n), '0);
			pkt.opa = random_word();
			pkt.opb = random_word();
			issue_op(pkt, issued);
			while (!(cdb_o.vld && cdb_o.rob_idx == pkt.rob_idx)) begin
				check_eq(64'(rdy_o.mult), 64'd0, "mult ready before its grant");
				next_cycle();
			end
			wait_broadcast(bc, seen);
			check_eq(bc.value, pkt.opa * pkt.opb, "mult product");
			check_eq(64'(bc.dest_tag), 64'(pkt.dest_tag), "mult dest_tag");
			check_eq(64'(seen), 64'(issued + MULT_CYCLES + 2), "mult broadcast edge");
			check_eq(64'(rdy_o.mult), 64'd1, "mult ready after grant");
			expect_no_broadcast(2);
		end
	endtask

	task automatic branch_outcomes();
		br_op_e          ops [7];
		logic [XLEN-1:0] opas [7];
		issue_pkt_t      pkt;
		cdb_pkt_t        bc;
		logic [XLEN-1:0] disp;
		logic            tk;
		int              issued;
		int              seen;
		int              n;
		ops = '{BR_BEQ, BR_BEQ, BR_BNE, BR_BNE, BR_BLT, BR_BLT, BR_BR};
		opas = '{64'd0, 64'd5, 64'd0, 64'd7, 64'hffff_ffff_ffff_fff0, 64'h10, 64'd3};
		for (n = 0; n < 7; n++) begin
			pkt = new_packet(SEL_BRANCH, 5'(12 + n), '0);
			pkt.br_op = ops[n];
			pkt.opa = opas[n];
			disp = random_word();
			pkt.opb = {48'h0, disp[15:2], 2'b00};
			pkt.pred_taken = n[0];
			tk = expected_taken(ops[n], opas[n]);
			issue_op(pkt, issued);
			next_cycle();
			check_eq(64'(br_res_o.vld), 64'd1, "branch outcome valid");
			check_eq(64'(br_res_o.rob_idx), 64'(pkt.rob_idx), "branch rob_idx");
			check_eq(64'(br_res_o.taken), 64'(tk), $sformatf("branch case %0d taken", n));
			check_eq(br_res_o.target, tk ? pkt.npc + pkt.opb : pkt.npc, "branch target");
			check_eq(64'(br_res_o.mispredict), 64'(tk != pkt.pred_taken), "branch mispredict");
			next_cycle();
			check_eq(64'(br_res_o.vld), 64'd0, "branch outcome lasts one cycle");
			wait_broadcast(bc, seen);
			check_eq(bc.value, pkt.npc, "link value");
			check_eq(64'(bc.dest_tag), 64'(pkt.dest_tag), "link dest_tag");
			check_eq(64'(bc.rob_idx), 64'(pkt.rob_idx), "link rob_idx");
			check_eq(64'(seen), 64'(issued + 2), "link broadcast edge");
			expect_no_broadcast(2);
		end
	endtask

	task automatic priority_and_credits();
		issue_pkt_t mul;
		issue_pkt_t pkt;
		cdb_pkt_t   bc;
		int         issued;
		int         seen;
		hold_credits = 1'b1;
		mul = new_packet(SEL_MULT, 5'd20, '0);
		mul.opa = random_word();
		mul.opb = random_word();
		issue_op(mul, issued);
		issue_op(new_packet(SEL_BRANCH, 5'd21, '0), issued);
		pkt = new_packet(SEL_ALU, 5'd22, '0);
		pkt.opa = random_word();
		issue_op(pkt, issued);
		repeat (10) next_cycle();
		check_eq(64'(bc_q.size()), 64'd2, "broadcasts with credits withheld");
		wait_broadcast(bc, seen);
		check_eq(64'(bc.rob_idx), 64'd21, "first broadcast is the branch");
		wait_broadcast(bc, seen);
		check_eq(64'(bc.rob_idx), 64'd22, "second broadcast is the alu op");
		// alu result lands before the branch one, both wait for credits
		issue_op(new_packet(SEL_ALU, 5'd23, '0), issued);
		issue_op(new_packet(SEL_BRANCH, 5'd24, '0), issued);
		expect_no_broadcast(6);
		check_eq(64'(rdy_o), 64'd0, "all units holding results");
		hold_credits = 1'b0;
		wait_broadcast(bc, seen);
		check_eq(64'(bc.rob_idx), 64'd24, "branch wins after credit return");
		wait_broadcast(bc, seen);
		check_eq(64'(bc.rob_idx), 64'd23, "alu follows branch");
		wait_broadcast(bc, seen);
		check_eq(64'(bc.rob_idx), 64'd20, "mult goes last");
		check_eq(bc.value, mul.opa * mul.opb, "held mult product");
		expect_no_broadcast(3);
	endtask

	task automatic branch_fix_squash();
		issue_pkt_t pkt;
		cdb_pkt_t   bc;
		int         issued;
		int         seen;
		pkt = new_packet(SEL_MULT, 5'd25, 4'b0100);
		pkt.opa = random_word();
		pkt.opb = random_word();
		issue_op(pkt, issued);
		next_cycle();
		fix_i = '{recover: 1'b1, correct: 1'b0, tag: 4'b0100};
		next_cycle();
		fix_i = '0;
		expect_no_broadcast(12);
		check_eq(64'(rdy_o.mult), 64'd1, "mult free after squash");
		pkt = new_packet(SEL_MULT, 5'd26, 4'b0100);
		pkt.opa = random_word();
		pkt.opb = random_word();
		issue_op(pkt, issued);
		next_cycle();
		fix_i = '{recover: 1'b0, correct: 1'b1, tag: 4'b0100};
		next_cycle();
		// a later recover on the same tag must miss the cleared mask
		fix_i = '{recover: 1'b1, correct: 1'b0, tag: 4'b0100};
		next_cycle();
		fix_i = '0;
		wait_broadcast(bc, seen);
		check_eq(64'(bc.rob_idx), 64'd26, "corrected mult broadcast");
		check_eq(bc.value, pkt.opa * pkt.opb, "corrected mult product");
		expect_no_broadcast(3);
	endtask

	initial begin : main
		rst = 1'b1;
		issue_i = '0;
		fix_i = '0;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		check_eq(64'(rdy_o), 64'h7, "ready bits after reset");
		check_eq(64'(cdb_o.vld), 64'd0, "cdb idle after reset");
		check_eq(64'(br_res_o.vld), 64'd0, "branch outcome idle after reset");
		alu_op_sweep();
		mult_random_pairs();
		branch_outcomes();
		priority_and_credits();
		branch_fix_squash();
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* design/exu_cluster.sv */
`timescale 1ns/100ps

module exu_cluster import exu_pkg::*; #(
	parameter int WB_CREDITS  = 2,
	parameter int MULT_CYCLES = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  issue_pkt_t issue_i,
	input  br_fix_t    fix_i,
	input  logic       credit_ret_i,
	output unit_rdy_t  rdy_o,
	output cdb_pkt_t   cdb_o,
	output br_res_t    br_res_o
);

	issue_pkt_t pkt;
	logic       alu_start, br_start, mult_start;
	logic       alu_grant, br_grant, mult_grant;
	logic       alu_rdy, br_rdy, mult_rdy;
	unit_res_t  alu_res, br_res, mult_res;

	assign rdy_o = '{alu: alu_rdy, br: br_rdy, mult: mult_rdy};

	exu_issue_stage i_exu_issue_stage (
		.clk          (clk),
		.rst          (rst),
		.issue_i      (issue_i),
		.fix_i        (fix_i),
		.rdy_i        (rdy_o),
		.alu_start_o  (alu_start),
		.br_start_o   (br_start),
		.mult_start_o (mult_start),
		.pkt_o        (pkt)
	);

	exu_alu i_exu_alu (
		.clk     (clk),
		.rst     (rst),
		.start_i (alu_start),
		.pkt_i   (pkt),
		.fix_i   (fix_i),
		.grant_i (alu_grant),
		.res_o   (alu_res),
		.rdy_o   (alu_rdy)
	);

	exu_branch i_exu_branch (
		.clk      (clk),
		.rst      (rst),
		.start_i  (br_start),
		.pkt_i    (pkt),
		.fix_i    (fix_i),
		.grant_i  (br_grant),
		.res_o    (br_res),
		.br_res_o (br_res_o),
		.rdy_o    (br_rdy)
	);

	exu_mult_seq #(.MULT_CYCLES(MULT_CYCLES)) i_exu_mult_seq (
		.clk     (clk),
		.rst     (rst),
		.start_i (mult_start),
		.pkt_i   (pkt),
		.fix_i   (fix_i),
		.grant_i (mult_grant),
		.res_o   (mult_res),
		.rdy_o   (mult_rdy)
	);

	exu_cdb_arbiter #(.WB_CREDITS(WB_CREDITS)) i_exu_cdb_arbiter (
		.clk          (clk),
		.rst          (rst),
		.alu_res_i    (alu_res),
		.br_res_i     (br_res),
		.mult_res_i   (mult_res),
		.credit_ret_i (credit_ret_i),
		.alu_grant_o  (alu_grant),
		.br_grant_o   (br_grant),
		.mult_grant_o (mult_grant),
		.cdb_o        (cdb_o),
		.credits_o    ()
	);

endmodule

/* design/exu_cdb_arbiter.sv */
`timescale 1ns/100ps

module exu_cdb_arbiter import exu_pkg::*; #(
	parameter int  WB_CREDITS = 2,
	localparam int CRED_W     = $clog2(WB_CREDITS + 1)
) (
	input  logic              clk,
	input  logic              rst,
	input  unit_res_t         alu_res_i,
	input  unit_res_t         br_res_i,
	input  unit_res_t         mult_res_i,
	input  logic              credit_ret_i,
	output logic              alu_grant_o,
	output logic              br_grant_o,
	output logic              mult_grant_o,
	output cdb_pkt_t          cdb_o,
	output logic [CRED_W-1:0] credits_o
);

	logic [CRED_W-1:0] credits_q;
	logic              has_cred;

	assign has_cred = credits_q != '0;

	// branch, then alu, then multiplier
	assign br_grant_o   = has_cred && br_res_i.vld;
	assign alu_grant_o  = has_cred && alu_res_i.vld && !br_res_i.vld;
	assign mult_grant_o = has_cred && mult_res_i.vld && !br_res_i.vld && !alu_res_i.vld;

	always_comb begin
		cdb_o = '0;
		if (br_grant_o)
			cdb_o = '{1'b1, br_res_i.dest_tag, br_res_i.rob_idx, br_res_i.value};
		else if (alu_grant_o)
			cdb_o = '{1'b1, alu_res_i.dest_tag, alu_res_i.rob_idx, alu_res_i.value};
		else if (mult_grant_o)
			cdb_o = '{1'b1, mult_res_i.dest_tag, mult_res_i.rob_idx, mult_res_i.value};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			credits_q <= CRED_W'(WB_CREDITS);
		end else begin
			case ({cdb_o.vld, credit_ret_i})
				2'b10:   credits_q <= credits_q - 1'b1;
				2'b01:   credits_q <= credits_q + 1'b1;
				default: credits_q <= credits_q;
			endcase
		end
	end

	assign credits_o = credits_q;

	a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({br_grant_o, alu_grant_o, mult_grant_o}));
	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		credits_q <= CRED_W'(WB_CREDITS));
	// downstream returns no more than it was given
	a_credit_ret: assert property (@(posedge clk) disable iff (rst)
		credit_ret_i |-> (credits_q < CRED_W'(WB_CREDITS)) || cdb_o.vld);

endmodule

/* design/exu_branch.sv */
`timescale 1ns/100ps

module exu_branch import exu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       start_i,
	input  issue_pkt_t pkt_i,
	input  br_fix_t    fix_i,
	input  logic       grant_i,
	output unit_res_t  res_o,
	output br_res_t    br_res_o,
	output logic       rdy_o
);

	logic      taken;
	logic      kill_new;
	logic      kill_held;
	unit_res_t link_q;
	br_res_t   br_res_q;

	always_comb begin
		case (pkt_i.br_op)
			BR_BEQ:  taken = (pkt_i.opa == '0);
			BR_BNE:  taken = (pkt_i.opa != '0);
			BR_BLT:  taken = pkt_i.opa[XLEN-1];
			default: taken = 1'b1;
		endcase
	end

	assign kill_new  = br_killed(pkt_i.br_mask, fix_i);
	assign kill_held = br_killed(link_q.br_mask, fix_i);

	// outcome lives for one cycle only
	always_ff @(posedge clk) begin
		if (rst) begin
			br_res_q.vld <= 1'b0;
		end else begin
			br_res_q.vld        <= start_i && !kill_new;
			br_res_q.rob_idx    <= pkt_i.rob_idx;
			br_res_q.taken      <= taken;
			br_res_q.mispredict <= taken != pkt_i.pred_taken;
			br_res_q.target     <= taken ? pkt_i.npc + pkt_i.opb : pkt_i.npc;
		end
	end

	// link value waits for the cdb like any other result
	always_ff @(posedge clk) begin
		if (rst) begin
			link_q.vld <= 1'b0;
		end else if (start_i) begin
			link_q.vld      <= !kill_new;
			link_q.dest_tag <= pkt_i.dest_tag;
			link_q.rob_idx  <= pkt_i.rob_idx;
			link_q.br_mask  <= br_mask_upd(pkt_i.br_mask, fix_i);
			link_q.value    <= pkt_i.npc;
		end else begin
			if (grant_i || kill_held)
				link_q.vld <= 1'b0;
			link_q.br_mask <= br_mask_upd(link_q.br_mask, fix_i);
		end
	end

	always_comb begin
		res_o = link_q;
		res_o.vld = link_q.vld && !kill_held;
	end

	assign br_res_o = br_res_q;
	assign rdy_o    = !start_i && (!link_q.vld || grant_i);

endmodule

/* design/exu_mult_seq.sv */
`timescale 1ns/100ps

module exu_mult_seq import exu_pkg::*; #(
	parameter int MULT_CYCLES = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       start_i,
	input  issue_pkt_t pkt_i,
	input  br_fix_t    fix_i,
	input  logic       grant_i,
	output unit_res_t  res_o,
	output logic       rdy_o
);

	localparam int STEP  = XLEN / MULT_CYCLES;
	localparam int CNT_W = (MULT_CYCLES > 1) ? $clog2(MULT_CYCLES) : 1;

	mult_state_e          state_q;
	logic [CNT_W-1:0]     cnt_q;
	logic [XLEN-1:0]      mcand_q;
	logic [XLEN-1:0]      mplier_q;
	logic [XLEN-1:0]      acc_q;
	logic [XLEN-1:0]      partial;
	logic [PRF_IDX_W-1:0] dest_tag_q;
	logic [ROB_IDX_W-1:0] rob_idx_q;
	logic [BR_MASK_W-1:0] br_mask_q;
	logic                 kill;

	assign kill    = br_killed(br_mask_q, fix_i);
	// one slice of the multiplier per cycle
	assign partial = mcand_q * XLEN'(mplier_q[STEP-1:0]);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= MULT_IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				MULT_IDLE: begin
					if (start_i && !br_killed(pkt_i.br_mask, fix_i)) begin
						state_q <= MULT_BUSY;
						cnt_q   <= '0;
					end
				end
				MULT_BUSY: begin
					if (kill)
						state_q <= MULT_IDLE;
					else if (cnt_q == CNT_W'(MULT_CYCLES - 1))
						state_q <= MULT_DONE;
					else
						cnt_q <= cnt_q + 1'b1;
				end
				MULT_DONE: if (grant_i || kill) state_q <= MULT_IDLE;
				default:   state_q <= MULT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == MULT_IDLE && start_i) begin
			mcand_q    <= pkt_i.opa;
			mplier_q   <= pkt_i.opb;
			acc_q      <= '0;
			dest_tag_q <= pkt_i.dest_tag;
			rob_idx_q  <= pkt_i.rob_idx;
			br_mask_q  <= br_mask_upd(pkt_i.br_mask, fix_i);
		end else begin
			br_mask_q <= br_mask_upd(br_mask_q, fix_i);
			if (state_q == MULT_BUSY) begin
				acc_q    <= acc_q + partial;
				mcand_q  <= mcand_q << STEP;
				mplier_q <= mplier_q >> STEP;
			end
		end
	end

	assign res_o = '{vld: (state_q == MULT_DONE) && !kill, dest_tag: dest_tag_q,
		rob_idx: rob_idx_q, br_mask: br_mask_q, value: acc_q};
	assign rdy_o = ((state_q == MULT_IDLE) && !start_i) || ((state_q == MULT_DONE) && grant_i);

	a_start_in_idle: assert property (@(posedge clk) disable iff (rst)
		start_i |-> state_q == MULT_IDLE);

endmodule

/* design/exu_alu.sv */
`timescale 1ns/100ps

module exu_alu import exu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       start_i,
	input  issue_pkt_t pkt_i,
	input  br_fix_t    fix_i,
	input  logic       grant_i,
	output unit_res_t  res_o,
	output logic       rdy_o
);

	localparam int SHAMT_W = $clog2(XLEN);

	logic [XLEN-1:0] alu_val;
	unit_res_t       res_q;
	logic            kill_new;
	logic            kill_held;

	always_comb begin
		case (pkt_i.alu_op)
			ALU_ADD:   alu_val = pkt_i.opa + pkt_i.opb;
			ALU_SUB:   alu_val = pkt_i.opa - pkt_i.opb;
			ALU_AND:   alu_val = pkt_i.opa & pkt_i.opb;
			ALU_OR:    alu_val = pkt_i.opa | pkt_i.opb;
			ALU_XOR:   alu_val = pkt_i.opa ^ pkt_i.opb;
			ALU_SLL:   alu_val = pkt_i.opa << pkt_i.opb[SHAMT_W-1:0];
			ALU_SRL:   alu_val = pkt_i.opa >> pkt_i.opb[SHAMT_W-1:0];
			ALU_CMPLT: alu_val = {{(XLEN-1){1'b0}}, $signed(pkt_i.opa) < $signed(pkt_i.opb)};
			default:   alu_val = '0;
		endcase
	end

	assign kill_new  = br_killed(pkt_i.br_mask, fix_i);
	assign kill_held = br_killed(res_q.br_mask, fix_i);

	always_ff @(posedge clk) begin
		if (rst) begin
			res_q.vld <= 1'b0;
		end else if (start_i) begin
			res_q.vld      <= !kill_new;
			res_q.dest_tag <= pkt_i.dest_tag;
			res_q.rob_idx  <= pkt_i.rob_idx;
			res_q.br_mask  <= br_mask_upd(pkt_i.br_mask, fix_i);
			res_q.value    <= alu_val;
		end else begin
			if (grant_i || kill_held)
				res_q.vld <= 1'b0;
			res_q.br_mask <= br_mask_upd(res_q.br_mask, fix_i);
		end
	end

	always_comb begin
		res_o = res_q;
		res_o.vld = res_q.vld && !kill_held;
	end

	// a start in flight will occupy the hold register
	assign rdy_o = !start_i && (!res_q.vld || grant_i);

endmodule

/* design/exu_issue_stage.sv */
`timescale 1ns/100ps

module exu_issue_stage import exu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  issue_pkt_t issue_i,
	input  br_fix_t    fix_i,
	input  unit_rdy_t  rdy_i,
	output logic       alu_start_o,
	output logic       br_start_o,
	output logic       mult_start_o,
	output issue_pkt_t pkt_o
);

	issue_pkt_t issue_nxt;
	issue_pkt_t pkt_q;
	logic       issue_ok;

	always_comb begin
		issue_nxt = issue_i;
		issue_nxt.vld = issue_i.vld && !br_killed(issue_i.br_mask, fix_i);
		issue_nxt.br_mask = br_mask_upd(issue_i.br_mask, fix_i);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pkt_q.vld <= 1'b0;
		end else begin
			pkt_q <= issue_nxt;
		end
	end

	assign alu_start_o  = pkt_q.vld && (pkt_q.sel == SEL_ALU);
	assign br_start_o   = pkt_q.vld && (pkt_q.sel == SEL_BRANCH);
	assign mult_start_o = pkt_q.vld && (pkt_q.sel == SEL_MULT);
	assign pkt_o        = pkt_q;

	always_comb begin
		case (issue_i.sel)
			SEL_ALU:    issue_ok = rdy_i.alu;
			SEL_BRANCH: issue_ok = rdy_i.br;
			SEL_MULT:   issue_ok = rdy_i.mult;
			default:    issue_ok = 1'b1;
		endcase
	end

	// source must only issue to a unit that reported ready
	a_issue_to_ready: assert property (@(posedge clk) disable iff (rst)
		issue_i.vld |-> issue_ok);

endmodule

/* design/exu_pkg.sv */
package exu_pkg;

	localparam int PRF_IDX_W = 6;
	localparam int ROB_IDX_W = 5;
	localparam int BR_MASK_W = 4;
	localparam int XLEN      = 64;

	typedef enum logic [1:0] {SEL_NONE, SEL_ALU, SEL_BRANCH, SEL_MULT} fu_sel_e;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_CMPLT
	} alu_op_e;

	// beq/bne test opa against zero, blt tests the sign of opa
	typedef enum logic [1:0] {BR_BEQ, BR_BNE, BR_BLT, BR_BR} br_op_e;

	typedef enum logic [1:0] {MULT_IDLE, MULT_BUSY, MULT_DONE} mult_state_e;

	typedef struct packed {
		logic                 vld;
		fu_sel_e              sel;
		alu_op_e              alu_op;
		br_op_e               br_op;
		logic [XLEN-1:0]      opa;
		logic [XLEN-1:0]      opb;
		logic [XLEN-1:0]      npc;
		logic                 pred_taken;
		logic [PRF_IDX_W-1:0] dest_tag;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [BR_MASK_W-1:0] br_mask;
		logic [BR_MASK_W-1:0] br_tag;
	} issue_pkt_t;

	typedef struct packed {
		logic                 vld;
		logic [PRF_IDX_W-1:0] dest_tag;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [BR_MASK_W-1:0] br_mask;
		logic [XLEN-1:0]      value;
	} unit_res_t;

	typedef struct packed {
		logic                 vld;
		logic [PRF_IDX_W-1:0] dest_tag;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic [XLEN-1:0]      value;
	} cdb_pkt_t;

	typedef struct packed {
		logic                 vld;
		logic [ROB_IDX_W-1:0] rob_idx;
		logic                 taken;
		logic                 mispredict;
		logic [XLEN-1:0]      target;
	} br_res_t;

	typedef struct packed {
		logic                 recover;
		logic                 correct;
		logic [BR_MASK_W-1:0] tag;
	} br_fix_t;

	typedef struct packed {
		logic alu;
		logic br;
		logic mult;
	} unit_rdy_t;

	// op depends on the mispredicted branch
	function automatic logic br_killed(logic [BR_MASK_W-1:0] mask, br_fix_t fix);
		return fix.recover && |(mask & fix.tag);
	endfunction

	function automatic logic [BR_MASK_W-1:0] br_mask_upd(logic [BR_MASK_W-1:0] mask,
			br_fix_t fix);
		return fix.correct ? (mask & ~fix.tag) : mask;
	endfunction

endpackage
